//--- design/satd_pkg.sv
`default_nettype none

package satd_pkg;

    ////////////////////////////////////////////////////////////
    // Block geometry and datapath widths
    ////////////////////////////////////////////////////////////

    // Block edge, also the transform length
    localparam int N_PT       = 8;
    localparam int SAMPLE_W   = 8;

    // Original minus current, -255..255
    localparam int DIFF_W     = 9;

    // After the horizontal pass, |x| <= 8*255
    localparam int ROW_COEF_W = 12;

    // After the vertical pass, |x| <= 64*255
    localparam int COEF_W     = 15;

    localparam int SATD_W     = 21;
    localparam int TOTAL_W    = 32;

    // Cycles from the edge that presents the eighth row to satd_valid
    localparam int LATENCY    = 3;

    ////////////////////////////////////////////////////////////
    // Row and coefficient types
    ////////////////////////////////////////////////////////////

    typedef logic [N_PT-1:0][SAMPLE_W-1:0] sample_row_t;

    typedef struct packed {
        sample_row_t org;
        sample_row_t cur;
    } row_in_t;

    typedef logic signed [ROW_COEF_W-1:0] hcoef_t;
    typedef logic signed [COEF_W-1:0]     vcoef_t;

    // Indexed by horizontal frequency
    typedef hcoef_t [N_PT-1:0] row_coef_t;

    // Indexed [vertical frequency][horizontal frequency]
    typedef vcoef_t [N_PT-1:0][N_PT-1:0] block_coef_t;

endpackage

`default_nettype wire

//--- design/row_hadamard.sv
`timescale 1ns/1ps
`default_nettype none

module row_hadamard (
    input  logic                clk,
    input  logic                rst,
    input  logic                row_valid,
    input  satd_pkg::row_in_t   row,
    output satd_pkg::row_coef_t hrow,
    output logic                hrow_valid
);

    import satd_pkg::*;

    logic signed [DIFF_W-1:0] diff [N_PT];

    // Butterfly network, bf[0] holds the differences
    hcoef_t bf [4][N_PT];

    // Differences, zero-extended so that the subtraction is signed
    for (genvar j = 0; j < N_PT; j++) begin : g_diff
        assign diff[j] = $signed({1'b0, row.org[j]}) - $signed({1'b0, row.cur[j]});
        assign bf[0][j] = hcoef_t'(diff[j]);
    end

    ////////////////////////////////////////////////////////////
    // Three radix-2 stages, strides 1, 2, 4
    ////////////////////////////////////////////////////////////

    // Natural order out, coef k gets sign (-1)^popcount(k & j)
    for (genvar s = 0; s < 3; s++) begin : g_stage
        for (genvar j = 0; j < N_PT; j++) begin : g_bf
            if ((j & (1 << s)) == 0) begin : g_sum
                assign bf[s+1][j] = bf[s][j] + bf[s][j + (1 << s)];
            end else begin : g_dif
                assign bf[s+1][j] = bf[s][j - (1 << s)] - bf[s][j];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hrow_valid <= 1'b0;
        end else begin
            hrow_valid <= row_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (row_valid) begin
            for (int k = 0; k < N_PT; k++) begin
                hrow[k] <= bf[3][k];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/column_hadamard.sv
`timescale 1ns/1ps
`default_nettype none

module column_hadamard (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hrow_valid,
    input  satd_pkg::row_coef_t   hrow,
    output satd_pkg::block_coef_t coef,
    output logic                  coef_valid
);

    import satd_pkg::*;

    logic [2:0] row_idx;
    logic       last_row;

    // Partial vertical sums over rows 0..6
    vcoef_t acc [N_PT][N_PT];
    vcoef_t nxt [N_PT][N_PT];

    assign last_row = (row_idx == 3'd7);

    ////////////////////////////////////////////////////////////
    // Vertical butterfly as signed accumulation
    ////////////////////////////////////////////////////////////

    // Row r enters coef m with sign (-1)^popcount(m & r)
    always_comb begin
        vcoef_t term;
        vcoef_t base;
        for (int m = 0; m < N_PT; m++) begin
            for (int c = 0; c < N_PT; c++) begin
                term = vcoef_t'($signed(hrow[c]));
                // Row 0 starts a new sum
                base = (row_idx == 3'd0) ? '0 : acc[m][c];
                if (^(3'(m) & row_idx)) begin
                    nxt[m][c] = base - term;
                end else begin
                    nxt[m][c] = base + term;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_idx    <= 3'd0;
            coef_valid <= 1'b0;
        end else begin
            coef_valid <= hrow_valid && last_row;
            if (hrow_valid) begin
                row_idx <= row_idx + 3'd1;
            end
        end
    end

    // Last row lands in coef so it holds while the next block accumulates
    always_ff @(posedge clk) begin
        if (hrow_valid) begin
            for (int m = 0; m < N_PT; m++) begin
                for (int c = 0; c < N_PT; c++) begin
                    if (last_row) begin
                        coef[m][c] <= nxt[m][c];
                    end else begin
                        acc[m][c] <= nxt[m][c];
                    end
                end
            end
        end
    end

    a_coef_after_row7 : assert property (
        @(posedge clk) disable iff (rst)
        coef_valid |-> $past(hrow_valid) && row_idx == 3'd0
    ) else $error("coef_valid without a preceding row 7");

endmodule

`default_nettype wire

//--- design/satd_accumulate.sv
`timescale 1ns/1ps
`default_nettype none

module satd_accumulate (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           coef_valid,
    input  satd_pkg::block_coef_t          coef,
    output logic [satd_pkg::SATD_W-1:0]    block_satd,
    output logic [satd_pkg::TOTAL_W-1:0]   total_satd,
    output logic                           satd_valid
);

    import satd_pkg::*;

    // Heap-ordered tree, node i sums nodes 2i+1 and 2i+2
    logic [SATD_W-1:0] node [2*N_PT*N_PT-1];

    function automatic logic [SATD_W-1:0] abs_coef(input vcoef_t c);
        logic signed [SATD_W-1:0] w;
        w = SATD_W'(c);
        return w[SATD_W-1] ? -w : w;
    endfunction

    ////////////////////////////////////////////////////////////
    // Absolute values and adder tree 64-32-16-8-4-2-1
    ////////////////////////////////////////////////////////////

    // Leaves occupy nodes 63..126
    for (genvar i = 0; i < N_PT*N_PT; i++) begin : g_leaf
        assign node[N_PT*N_PT-1+i] = abs_coef(coef[i / N_PT][i % N_PT]);
    end

    for (genvar i = 0; i < N_PT*N_PT-1; i++) begin : g_add
        assign node[i] = node[2*i+1] + node[2*i+2];
    end

    ////////////////////////////////////////////////////////////
    // Block result and running total
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            satd_valid <= 1'b0;
            block_satd <= '0;
            total_satd <= '0;
        end else begin
            satd_valid <= coef_valid;
            if (coef_valid) begin
                block_satd <= node[0];
                // Wraps at 2^32
                total_satd <= total_satd + TOTAL_W'(node[0]);
            end
        end
    end

    a_single_pulse : assert property (
        @(posedge clk) disable iff (rst)
        satd_valid |=> !satd_valid
    ) else $error("satd_valid high on two cycles in a row");

    a_satd_range : assert property (
        @(posedge clk) disable iff (rst)
        block_satd <= SATD_W'(N_PT*N_PT*((1 << SAMPLE_W) - 1)*N_PT*N_PT)
    ) else $error("block_satd above the 8x8 Hadamard bound");

endmodule

`default_nettype wire

//--- design/satd_8x8.sv
`timescale 1ns/1ps
`default_nettype none

module satd_8x8 (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           row_valid,
    input  satd_pkg::row_in_t              row,
    output logic [satd_pkg::SATD_W-1:0]    block_satd,
    output logic [satd_pkg::TOTAL_W-1:0]   total_satd,
    output logic                           satd_valid
);

    import satd_pkg::*;

    row_coef_t   hrow;
    logic        hrow_valid;
    block_coef_t coef;
    logic        coef_valid;

    ////////////////////////////////////////////////////////////
    // Horizontal, vertical, sum of absolutes
    ////////////////////////////////////////////////////////////

    row_hadamard u_row (
        .clk        (clk),
        .rst        (rst),
        .row_valid  (row_valid),
        .row        (row),
        .hrow       (hrow),
        .hrow_valid (hrow_valid)
    );

    column_hadamard u_col (
        .clk        (clk),
        .rst        (rst),
        .hrow_valid (hrow_valid),
        .hrow       (hrow),
        .coef       (coef),
        .coef_valid (coef_valid)
    );

    satd_accumulate u_acc (
        .clk        (clk),
        .rst        (rst),
        .coef_valid (coef_valid),
        .coef       (coef),
        .block_satd (block_satd),
        .total_satd (total_satd),
        .satd_valid (satd_valid)
    );

endmodule

`default_nettype wire

//--- testbench/tb_satd_8x8.sv
`timescale 1ns/1ps
`default_nettype none

module tb_satd_8x8;

    import satd_pkg::*;

    logic               clk;
    logic               rst;
    logic               row_valid;
    row_in_t            row;
    logic [SATD_W-1:0]  block_satd;
    logic [TOTAL_W-1:0] total_satd;
    logic               satd_valid;

    // Expected block values, and the edges that presented each eighth row
    logic [SATD_W-1:0]  exp_q [$];
    int                 last_edge_q [$];
    logic [TOTAL_W-1:0] exp_total = '0;
    int                 cyc = 0;
    int                 row_cnt = 0;
    int                 errors = 0;
    int                 drive_errors = 0;

    int                 fd;
    int                 gap;
    int                 val;
    int                 t;
    string              line;
    logic [SAMPLE_W-1:0] smp [2*N_PT];

    satd_8x8 dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Idle cycles first, then one row from smp
    task automatic send_row(input int idle);
        for (int i = 0; i < idle; i++) begin
            @(posedge clk);
            row_valid <= 1'b0;
        end
        @(posedge clk);
        row_valid <= 1'b1;
        for (int j = 0; j < N_PT; j++) begin
            row.org[j] <= smp[j];
            row.cur[j] <= smp[N_PT + j];
        end
    endtask

    task automatic check_block();
        logic [SATD_W-1:0] e;
        int                edge_no;
        assert (exp_q.size() != 0 && last_edge_q.size() != 0) else begin
            $display("satd_valid pulsed at %0t with no block pending", $time);
            errors++;
        end
        if (exp_q.size() != 0 && last_edge_q.size() != 0) begin
            e = exp_q.pop_front();
            edge_no = last_edge_q.pop_front();
            exp_total = exp_total + TOTAL_W'(e);
            assert (block_satd == e) else begin
                $display("Error at %0t: block_satd expected %0d, got %0d", $time, e, block_satd);
                errors++;
            end
            assert (total_satd == exp_total) else begin
                $display("Error at %0t: total_satd expected %0d, got %0d",
                         $time, exp_total, total_satd);
                errors++;
            end
            assert (cyc == edge_no + LATENCY) else begin
                $display("Error at %0t: satd_valid cycle expected %0d, got %0d",
                         $time, edge_no + LATENCY, cyc);
                errors++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checker, sampled on the falling edge
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            row_cnt = 0;
        end else begin
            if (row_valid) begin
                // Presented on the rising edge just counted in cyc
                if (row_cnt == N_PT - 1) begin
                    last_edge_q.push_back(cyc);
                end
                row_cnt = (row_cnt + 1) % N_PT;
            end
            if (satd_valid) begin
                check_block();
            end
        end
    end

    initial begin
        rst       <= 1'b1;
        row_valid <= 1'b0;
        row       <= '0;
        fd = $fopen("testbench/satd_cases.txt", "r");
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (satd_valid == 1'b0) else begin
            $display("Error at %0t: satd_valid expected 0, got %0b", $time, satd_valid);
            drive_errors++;
        end
        assert (block_satd == '0) else begin
            $display("Error at %0t: block_satd expected 0, got %0d", $time, block_satd);
            drive_errors++;
        end
        assert (total_satd == '0) else begin
            $display("Error at %0t: total_satd expected 0, got %0d", $time, total_satd);
            drive_errors++;
        end
        assert (fd != 0) else begin
            $display("Could not open the stimulus file testbench/satd_cases.txt");
            drive_errors++;
        end
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "row %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            gap, smp[0], smp[1], smp[2], smp[3], smp[4], smp[5], smp[6],
                            smp[7], smp[8], smp[9], smp[10], smp[11], smp[12], smp[13],
                            smp[14], smp[15]) == 17) begin
                    send_row(gap);
                end else if ($sscanf(line, "expect %d", val) == 1) begin
                    exp_q.push_back(SATD_W'(val));
                end
            end
            $fclose(fd);
        end
        @(posedge clk);
        row_valid <= 1'b0;
        for (t = 0; t < 10 * LATENCY && exp_q.size() != 0; t++) begin
            @(posedge clk);
        end
        assert (exp_q.size() == 0) else begin
            $display("Timed out waiting for %0d block results", exp_q.size());
            drive_errors++;
        end
        repeat (LATENCY + 2) @(posedge clk);
        $display("Result errors: %0d, other errors: %0d", errors, drive_errors);
        if (errors + drive_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/satd_cases.txt
# row <idle cycles before the row> <org[0..7] hex> <cur[0..7] hex>
# expect <block SATD, decimal>
row 2 12 34 56 78 9a bc de f0 12 34 56 78 9a bc de f0
row 0 01 23 45 67 89 ab cd ef 01 23 45 67 89 ab cd ef
row 0 ff 00 80 7f 40 c0 20 e0 ff 00 80 7f 40 c0 20 e0
row 0 11 22 33 44 55 66 77 88 11 22 33 44 55 66 77 88
row 1 99 aa bb cc dd ee ff 00 99 aa bb cc dd ee ff 00
row 0 0f 1e 2d 3c 4b 5a 69 78 0f 1e 2d 3c 4b 5a 69 78
row 0 87 96 a5 b4 c3 d2 e1 f0 87 96 a5 b4 c3 d2 e1 f0
row 0 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa 55 aa
expect 0
row 0 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 1 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 0 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 3 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 0 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 0 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 2 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
row 0 15 25 35 45 55 65 75 85 10 20 30 40 50 60 70 80
expect 320
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
row 0 00 00 00 00 00 00 00 00 ff ff ff ff ff ff ff ff
expect 16320
row 3 11 12 13 14 15 16 17 18 10 10 10 10 10 10 10 10
row 0 12 14 16 18 1a 1c 1e 20 10 10 10 10 10 10 10 10
row 1 13 16 19 1c 1f 22 25 28 10 10 10 10 10 10 10 10
row 0 14 18 1c 20 24 28 2c 30 10 10 10 10 10 10 10 10
row 0 15 1a 1f 24 29 2e 33 38 10 10 10 10 10 10 10 10
row 4 16 1c 22 28 2e 34 3a 40 10 10 10 10 10 10 10 10
row 0 17 1e 25 2c 33 3a 41 48 10 10 10 10 10 10 10 10
row 1 18 20 28 30 38 40 48 50 10 10 10 10 10 10 10 10
expect 4096
row 0 42 3f 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40 40
row 0 44 3e 40 40 40 40 40 40 40 40 40 40 40 40 40 40
expect 256
row 0 94 6c 94 6c 94 6c 94 6c 80 80 80 80 80 80 80 80
row 0 6c 94 6c 94 6c 94 6c 94 80 80 80 80 80 80 80 80
row 2 94 6c 94 6c 94 6c 94 6c 80 80 80 80 80 80 80 80
row 0 6c 94 6c 94 6c 94 6c 94 80 80 80 80 80 80 80 80
row 0 94 6c 94 6c 94 6c 94 6c 80 80 80 80 80 80 80 80
row 0 6c 94 6c 94 6c 94 6c 94 80 80 80 80 80 80 80 80
row 0 94 6c 94 6c 94 6c 94 6c 80 80 80 80 80 80 80 80
row 0 6c 94 6c 94 6c 94 6c 94 80 80 80 80 80 80 80 80
expect 1280

//--- satd_8x8.f
design/satd_pkg.sv
design/row_hadamard.sv
design/column_hadamard.sv
design/satd_accumulate.sv
design/satd_8x8.sv
testbench/tb_satd_8x8.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run tb_satd_8x8 with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_satd_8x8 \
    -f satd_8x8.f -o sim_satd > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_satd > sim.log 2>&1 \
    && grep -qx "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
